/* hw/rename_pkg.sv */
// Rename widths, register index types, rename request/response and commit structs
`default_nettype none

package rename_pkg;

  // ==============================
  // Core widths
  // ==============================

  // Lanes renamed per cycle
  localparam int unsigned DECODE_WIDTH = 2;
  // Lanes retired per cycle
  localparam int unsigned COMMIT_WIDTH = 2;
  localparam int unsigned ARCH_REG_NUM = 32;
  // Must stay a power of two, free-list pointers wrap naturally
  localparam int unsigned PHY_REG_NUM  = 64;

  localparam int unsigned AREG_W = $clog2(ARCH_REG_NUM);
  localparam int unsigned PREG_W = $clog2(PHY_REG_NUM);

  // ==============================
  // Index and count types
  // ==============================

  typedef logic [AREG_W-1:0] areg_t;
  typedef logic [PREG_W-1:0] preg_t;
  // One extra bit so a full list can be counted
  typedef logic [PREG_W:0]   fl_cnt_t;

  // Decoded instruction, architectural names only
  typedef struct packed {
    areg_t rd;
    areg_t rs1;
    areg_t rs2;
  } ren_req_t;

  // Renamed instruction
  typedef struct packed {
    preg_t prd;
    preg_t prs1;
    preg_t prs2;
    preg_t old_prd;
  } ren_rsp_t;

  // Retiring instruction
  typedef struct packed {
    areg_t rd;
    preg_t prd;
    preg_t old_prd;
  } commit_t;

  // Free-list restore point
  typedef struct packed {
    preg_t   head;
    preg_t   tail;
    fl_cnt_t cnt;
  } fl_ptr_t;

endpackage

`default_nettype wire

/* hw/free_list.sv */
// Free list of physical registers: multi-lane allocate, multi-lane release, flush restore
`timescale 1ns/1ps
`default_nettype none

module free_list #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DECODE_WIDTH,
  parameter int unsigned COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
  parameter int unsigned ARCH_REG_NUM = rename_pkg::ARCH_REG_NUM,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::PHY_REG_NUM
) (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic                                  flush_i,
  input  rename_pkg::fl_ptr_t                   restore_i,
  input  logic [DECODE_WIDTH-1:0]               alloc_i,
  output logic                                  alloc_ready_o,
  output rename_pkg::preg_t [DECODE_WIDTH-1:0]  preg_o,
  input  logic [COMMIT_WIDTH-1:0]               free_valid_i,
  input  rename_pkg::preg_t [COMMIT_WIDTH-1:0]  free_preg_i,
  output rename_pkg::fl_cnt_t                   cnt_o
);

  localparam int unsigned ANUM_W = $clog2(DECODE_WIDTH + 1);
  localparam int unsigned FNUM_W = $clog2(COMMIT_WIDTH + 1);

  // Circular storage plus pointers
  rename_pkg::preg_t [PHY_REG_NUM-1:0]  list_q, list_d;
  rename_pkg::preg_t                    head_q, head_d;
  rename_pkg::preg_t                    tail_q, tail_d;
  rename_pkg::fl_cnt_t                  cnt_q, cnt_d;

  // Per-lane indices and lane counts
  logic [DECODE_WIDTH-1:0]              alloc_go;
  logic [ANUM_W-1:0]                    alloc_num;
  logic [FNUM_W-1:0]                    free_num;
  rename_pkg::preg_t [DECODE_WIDTH-1:0] rd_idx;
  rename_pkg::preg_t [COMMIT_WIDTH-1:0] wr_idx;

  // Whole group must fit, independent of how many lanes are valid
  assign alloc_ready_o = cnt_q >= rename_pkg::fl_cnt_t'(DECODE_WIDTH);
  assign alloc_go      = alloc_i & {DECODE_WIDTH{alloc_ready_o}};
  assign cnt_o         = cnt_q;

  // ==============================
  // Allocation side
  // ==============================
  always_comb begin
    alloc_num = ANUM_W'($countones(alloc_go));
    // Read index steps once per valid lane, wraps at list size
    rd_idx[0] = head_q;
    for (int i = 1; i < DECODE_WIDTH; i++) begin
      rd_idx[i] = alloc_go[i-1] ? rd_idx[i-1] + 1'b1 : rd_idx[i-1];
    end
    for (int i = 0; i < DECODE_WIDTH; i++) begin
      preg_o[i] = alloc_go[i] ? list_q[rd_idx[i]] : '0;
    end
  end

  // ==============================
  // Release side
  // ==============================
  always_comb begin
    free_num  = FNUM_W'($countones(free_valid_i));
    wr_idx[0] = tail_q;
    for (int i = 1; i < COMMIT_WIDTH; i++) begin
      wr_idx[i] = free_valid_i[i-1] ? wr_idx[i-1] + 1'b1 : wr_idx[i-1];
    end
    // Release never blocks
    list_d = list_q;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (free_valid_i[i]) begin
        list_d[wr_idx[i]] = free_preg_i[i];
      end
    end
  end

  // Pointer and count update, flush takes the committed restore point
  always_comb begin
    head_d = head_q + rename_pkg::preg_t'(alloc_num);
    tail_d = tail_q + rename_pkg::preg_t'(free_num);
    cnt_d  = cnt_q + rename_pkg::fl_cnt_t'(free_num) - rename_pkg::fl_cnt_t'(alloc_num);
    if (flush_i) begin
      head_d = restore_i.head;
      tail_d = restore_i.tail;
      cnt_d  = restore_i.cnt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Slot i holds register i, first ARCH_REG_NUM are mapped already
      for (int i = 0; i < PHY_REG_NUM; i++) begin
        list_q[i] <= rename_pkg::preg_t'(i);
      end
      head_q <= rename_pkg::preg_t'(ARCH_REG_NUM);
      tail_q <= '0;
      cnt_q  <= rename_pkg::fl_cnt_t'(PHY_REG_NUM - ARCH_REG_NUM);
    end else begin
      list_q <= list_d;
      head_q <= head_d;
      tail_q <= tail_d;
      cnt_q  <= cnt_d;
    end
  end

endmodule

`default_nettype wire

/* hw/map_table.sv */
// Speculative architectural-to-physical map: group lookup, fired-lane write, flush restore
`timescale 1ns/1ps
`default_nettype none

module map_table #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DECODE_WIDTH,
  parameter int unsigned ARCH_REG_NUM = rename_pkg::ARCH_REG_NUM
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush_i,
  input  rename_pkg::preg_t [ARCH_REG_NUM-1:0]    arch_map_i,
  input  rename_pkg::ren_req_t [DECODE_WIDTH-1:0] req_i,
  input  logic [DECODE_WIDTH-1:0]                 wr_en_i,
  input  rename_pkg::preg_t [DECODE_WIDTH-1:0]    wr_preg_i,
  output rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] look_o
);

  rename_pkg::preg_t [ARCH_REG_NUM-1:0] map_q, map_d;

  // Lookups see the table as it stood at the start of the cycle
  // Same-group hazards are fixed later in rename_merge
  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      // prd slot left empty, filled from the free list downstream
      look_o[k].prd     = '0;
      look_o[k].prs1    = map_q[req_i[k].rs1];
      look_o[k].prs2    = map_q[req_i[k].rs2];
      look_o[k].old_prd = map_q[req_i[k].rd];
    end
  end

  // ==============================
  // Next map state
  // ==============================
  always_comb begin
    map_d = map_q;
    // Ascending lane order, so the youngest writer of an rd wins
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      if (wr_en_i[k]) begin
        map_d[req_i[k].rd] = wr_preg_i[k];
      end
    end
    // Flush drops all speculative writes
    if (flush_i) begin
      map_d = arch_map_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Identity map out of reset
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        map_q[i] <= rename_pkg::preg_t'(i);
      end
    end else begin
      map_q <= map_d;
    end
  end

endmodule

`default_nettype wire

/* hw/commit_tracker.sv */
// Architectural free-list pointers and architectural map, advanced by retiring lanes
`timescale 1ns/1ps
`default_nettype none

module commit_tracker #(
  parameter int unsigned COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
  parameter int unsigned ARCH_REG_NUM = rename_pkg::ARCH_REG_NUM,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::PHY_REG_NUM
) (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic [COMMIT_WIDTH-1:0]                cm_valid_i,
  input  rename_pkg::commit_t [COMMIT_WIDTH-1:0] cm_i,
  output logic [COMMIT_WIDTH-1:0]                free_valid_o,
  output rename_pkg::preg_t [COMMIT_WIDTH-1:0]   free_preg_o,
  output rename_pkg::fl_ptr_t                    restore_o,
  output rename_pkg::preg_t [ARCH_REG_NUM-1:0]   arch_map_o
);

  localparam int unsigned CNUM_W = $clog2(COMMIT_WIDTH + 1);

  logic [CNUM_W-1:0]                    cm_num;
  rename_pkg::preg_t                    arch_head_q, arch_tail_q;
  rename_pkg::preg_t [ARCH_REG_NUM-1:0] arch_map_q, arch_map_d;

  // Old mappings become free once their overwriter retires
  always_comb begin
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      free_valid_o[i] = cm_valid_i[i];
      free_preg_o[i]  = cm_i[i].old_prd;
    end
  end

  assign cm_num = CNUM_W'($countones(cm_valid_i));

  // Each retirement consumes one entry and returns one, count is constant
  assign restore_o.head = arch_head_q;
  assign restore_o.tail = arch_tail_q;
  assign restore_o.cnt  = rename_pkg::fl_cnt_t'(PHY_REG_NUM - ARCH_REG_NUM);
  assign arch_map_o     = arch_map_q;

  // Committed map, youngest lane wins on equal rd
  always_comb begin
    arch_map_d = arch_map_q;
    for (int i = 0; i < COMMIT_WIDTH; i++) begin
      if (cm_valid_i[i]) begin
        arch_map_d[cm_i[i].rd] = cm_i[i].prd;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      // Matches free-list reset state
      arch_head_q <= rename_pkg::preg_t'(ARCH_REG_NUM);
      arch_tail_q <= '0;
      for (int i = 0; i < ARCH_REG_NUM; i++) begin
        arch_map_q[i] <= rename_pkg::preg_t'(i);
      end
    end else begin
      arch_head_q <= arch_head_q + rename_pkg::preg_t'(cm_num);
      arch_tail_q <= arch_tail_q + rename_pkg::preg_t'(cm_num);
      arch_map_q  <= arch_map_d;
    end
  end

endmodule

`default_nettype wire

/* hw/rename_merge.sv */
// Renamed group assembly: new prd per lane plus intra-group dependency bypass
`timescale 1ns/1ps
`default_nettype none

module rename_merge #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DECODE_WIDTH
) (
  input  logic [DECODE_WIDTH-1:0]                 fire_i,
  input  rename_pkg::preg_t [DECODE_WIDTH-1:0]    preg_i,
  input  rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] look_i,
  output rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] rsp_o
);

  // The map is one-to-one, so equal raw lookups mean equal architectural names
  // Lane j's old_prd therefore identifies its rd without the request itself
  always_comb begin
    for (int k = 0; k < DECODE_WIDTH; k++) begin
      // Idle lanes stay all zero
      rsp_o[k] = '0;
      if (fire_i[k]) begin
        rsp_o[k].prd     = preg_i[k];
        rsp_o[k].prs1    = look_i[k].prs1;
        rsp_o[k].prs2    = look_i[k].prs2;
        rsp_o[k].old_prd = look_i[k].old_prd;
        // Scan older lanes upward, the nearest older writer ends up on top
        for (int j = 0; j < k; j++) begin
          if (fire_i[j] && (look_i[j].old_prd == look_i[k].prs1)) begin
            rsp_o[k].prs1 = preg_i[j];
          end
          if (fire_i[j] && (look_i[j].old_prd == look_i[k].prs2)) begin
            rsp_o[k].prs2 = preg_i[j];
          end
          // WAW inside the group, old mapping is the older lane's new one
          if (fire_i[j] && (look_i[j].old_prd == look_i[k].old_prd)) begin
            rsp_o[k].old_prd = preg_i[j];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hw/rename_unit.sv */
// Rename top level: free list, map table, commit tracker and group merge
`timescale 1ns/1ps
`default_nettype none

module rename_unit #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DECODE_WIDTH,
  parameter int unsigned COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH,
  parameter int unsigned ARCH_REG_NUM = rename_pkg::ARCH_REG_NUM,
  parameter int unsigned PHY_REG_NUM  = rename_pkg::PHY_REG_NUM
) (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic                                    flush_i,
  input  logic [DECODE_WIDTH-1:0]                 ren_valid_i,
  input  rename_pkg::ren_req_t [DECODE_WIDTH-1:0] ren_req_i,
  output logic                                    ren_ready_o,
  output rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] ren_rsp_o,
  input  logic [COMMIT_WIDTH-1:0]                 cm_valid_i,
  input  rename_pkg::commit_t [COMMIT_WIDTH-1:0]  cm_i
);

  logic [DECODE_WIDTH-1:0]                 fire;
  rename_pkg::preg_t [DECODE_WIDTH-1:0]    new_preg;
  rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] look;
  logic [COMMIT_WIDTH-1:0]                 cm_free_valid;
  rename_pkg::preg_t [COMMIT_WIDTH-1:0]    cm_free_preg;
  rename_pkg::fl_ptr_t                     restore;
  rename_pkg::preg_t [ARCH_REG_NUM-1:0]    arch_map;

  // A lane renames only with valid and ready both high
  assign fire = ren_valid_i & {DECODE_WIDTH{ren_ready_o}};

  free_list #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH),
    .ARCH_REG_NUM (ARCH_REG_NUM),
    .PHY_REG_NUM  (PHY_REG_NUM)
  ) u_free_list (
    .clk           (clk),
    .rst_n         (rst_n),
    .flush_i       (flush_i),
    .restore_i     (restore),
    .alloc_i       (fire),
    .alloc_ready_o (ren_ready_o),
    .preg_o        (new_preg),
    .free_valid_i  (cm_free_valid),
    .free_preg_i   (cm_free_preg),
    // Occupancy only observed hierarchically
    .cnt_o         ()
  );

  map_table #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .ARCH_REG_NUM (ARCH_REG_NUM)
  ) u_map_table (
    .clk        (clk),
    .rst_n      (rst_n),
    .flush_i    (flush_i),
    .arch_map_i (arch_map),
    .req_i      (ren_req_i),
    .wr_en_i    (fire),
    .wr_preg_i  (new_preg),
    .look_o     (look)
  );

  commit_tracker #(
    .COMMIT_WIDTH (COMMIT_WIDTH),
    .ARCH_REG_NUM (ARCH_REG_NUM),
    .PHY_REG_NUM  (PHY_REG_NUM)
  ) u_commit_tracker (
    .clk          (clk),
    .rst_n        (rst_n),
    .cm_valid_i   (cm_valid_i),
    .cm_i         (cm_i),
    .free_valid_o (cm_free_valid),
    .free_preg_o  (cm_free_preg),
    .restore_o    (restore),
    .arch_map_o   (arch_map)
  );

  rename_merge #(
    .DECODE_WIDTH (DECODE_WIDTH)
  ) u_rename_merge (
    .fire_i (fire),
    .preg_i (new_preg),
    .look_i (look),
    .rsp_o  (ren_rsp_o)
  );

endmodule

`default_nettype wire

/* dv/rename_checker.sv */
// Concurrent assertions on the rename unit ports, bound into rename_unit
`timescale 1ns/1ps
`default_nettype none

module rename_checker #(
  parameter int unsigned DECODE_WIDTH = rename_pkg::DECODE_WIDTH,
  parameter int unsigned COMMIT_WIDTH = rename_pkg::COMMIT_WIDTH
) (
  input logic                                    clk,
  input logic                                    rst_n,
  input logic                                    flush_i,
  input logic [DECODE_WIDTH-1:0]                 ren_valid_i,
  input logic                                    ren_ready_i,
  input rename_pkg::ren_rsp_t [DECODE_WIDTH-1:0] ren_rsp_i,
  input logic [COMMIT_WIDTH-1:0]                 cm_valid_i
);

  // Failed assertions, read by the testbench
  int unsigned fail_cnt = 0;

  logic [DECODE_WIDTH-1:0] fire;

  assign fire = ren_valid_i & {DECODE_WIDTH{ren_ready_i}};

  // ==============================
  // Port rules
  // ==============================

  // Full list out of reset
  ready_after_reset_a: assert property (@(posedge clk) $rose(rst_n) |-> ren_ready_i)
    else begin
      $error("ren_ready_o low on first edge after reset");
      fail_cnt = fail_cnt + 1;
    end

  // Flush and retire are exclusive
  no_flush_with_commit_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(flush_i && (|cm_valid_i)))
    else begin
      $error("flush_i and cm_valid_i high in the same cycle");
      fail_cnt = fail_cnt + 1;
    end

  for (genvar k = 0; k < DECODE_WIDTH; k++) begin : g_lane
    // Idle lane drives zeros
    idle_lane_zero_a: assert property (@(posedge clk) disable iff (!rst_n)
      !fire[k] |-> (ren_rsp_i[k] == '0))
      else begin
        $error("lane %0d not fired but response not zero", k);
        fail_cnt = fail_cnt + 1;
      end
  end

  // Every pair of fired lanes gets its own register
  for (genvar i = 0; i < DECODE_WIDTH; i++) begin : g_pair_i
    for (genvar j = i + 1; j < DECODE_WIDTH; j++) begin : g_pair_j
      distinct_prd_a: assert property (@(posedge clk) disable iff (!rst_n)
        (fire[i] && fire[j]) |-> (ren_rsp_i[i].prd != ren_rsp_i[j].prd))
        else begin
          $error("lanes %0d and %0d share prd", i, j);
          fail_cnt = fail_cnt + 1;
        end
    end
  end

endmodule

`default_nettype wire

/* dv/rename_tb.sv */
// Rename unit testbench: clock, reset, reference model, directed and random tests, report
`timescale 1ns/1ps
`default_nettype none

module rename_tb;

  localparam int unsigned DW = rename_pkg::DECODE_WIDTH;
  localparam int unsigned CW = rename_pkg::COMMIT_WIDTH;
  localparam int unsigned AN = rename_pkg::ARCH_REG_NUM;
  localparam int unsigned PN = rename_pkg::PHY_REG_NUM;
  // Tests need roughly 150 cycles, wide margin on top
  localparam int unsigned MAX_CYCLES = 2000;

  logic                          clk = 1'b0;
  logic                          rst_n;
  logic                          flush;
  logic [DW-1:0]                 ren_valid;
  rename_pkg::ren_req_t [DW-1:0] ren_req;
  logic                          ren_ready;
  rename_pkg::ren_rsp_t [DW-1:0] ren_rsp;
  logic [CW-1:0]                 cm_valid;
  rename_pkg::commit_t [CW-1:0]  cm;

  // Reference model state
  rename_pkg::preg_t   free_q[$];
  rename_pkg::preg_t   arch_free_q[$];
  rename_pkg::preg_t   spec_map[AN];
  rename_pkg::preg_t   arch_map[AN];
  rename_pkg::commit_t inflight_q[$];
  rename_pkg::ren_req_t [DW-1:0] reqs;

  int seed = 32'h74b3_c0ad;
  int err_cnt = 0;
  int check_cnt = 0;
  int test_cnt = 0;
  int bad_tests = 0;
  int err_base = 0;
  int unsigned cycle_cnt = 0;

  always #20 clk = ~clk;

  // ==============================
  // DUT and bound checker
  // ==============================
  rename_unit #(
    .DECODE_WIDTH (DW),
    .COMMIT_WIDTH (CW),
    .ARCH_REG_NUM (AN),
    .PHY_REG_NUM  (PN)
  ) u_rename_unit (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush),
    .ren_valid_i (ren_valid),
    .ren_req_i   (ren_req),
    .ren_ready_o (ren_ready),
    .ren_rsp_o   (ren_rsp),
    .cm_valid_i  (cm_valid),
    .cm_i        (cm)
  );

  bind rename_unit rename_checker #(
    .DECODE_WIDTH (DECODE_WIDTH),
    .COMMIT_WIDTH (COMMIT_WIDTH)
  ) u_rename_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .ren_valid_i (ren_valid_i),
    .ren_ready_i (ren_ready_o),
    .ren_rsp_i   (ren_rsp_o),
    .cm_valid_i  (cm_valid_i)
  );

  // Run limit
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // Value errors plus checker assertion failures
  function automatic int errors_now();
    return err_cnt + int'(u_rename_unit.u_rename_checker.fail_cnt);
  endfunction

  function automatic rename_pkg::ren_req_t mk_req(input int rd, input int rs1, input int rs2);
    rename_pkg::ren_req_t r;
    r.rd  = rename_pkg::areg_t'(rd);
    r.rs1 = rename_pkg::areg_t'(rs1);
    r.rs2 = rename_pkg::areg_t'(rs2);
    return r;
  endfunction

  task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_cnt++;
    assert (got === exp) else begin
      err_cnt++;
      $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // ==============================
  // Cycle tasks
  // ==============================

  // One rename group, checked against the model, model advanced lane by lane
  task automatic rename_cycle(input logic [DW-1:0] valid, input rename_pkg::ren_req_t [DW-1:0] rq);
    rename_pkg::ren_rsp_t exp_rsp;
    rename_pkg::commit_t  inst;
    logic                 exp_ready;
    @(negedge clk);
    flush     = 1'b0;
    cm_valid  = '0;
    ren_valid = valid;
    ren_req   = rq;
    #1;
    exp_ready = free_q.size() >= DW;
    check_val(ren_ready, exp_ready, "ren_ready_o");
    check_val(u_rename_unit.u_free_list.cnt_o, free_q.size(), "free count");
    for (int k = 0; k < DW; k++) begin
      exp_rsp = '0;
      if (valid[k] && exp_ready) begin
        // Earlier lanes already updated the map, which covers the bypass
        exp_rsp.prd     = free_q.pop_front();
        exp_rsp.prs1    = spec_map[rq[k].rs1];
        exp_rsp.prs2    = spec_map[rq[k].rs2];
        exp_rsp.old_prd = spec_map[rq[k].rd];
        spec_map[rq[k].rd] = exp_rsp.prd;
        inst.rd      = rq[k].rd;
        inst.prd     = exp_rsp.prd;
        inst.old_prd = exp_rsp.old_prd;
        inflight_q.push_back(inst);
      end
      check_val(ren_rsp[k].prd, exp_rsp.prd, $sformatf("lane %0d prd", k));
      check_val(ren_rsp[k].prs1, exp_rsp.prs1, $sformatf("lane %0d prs1", k));
      check_val(ren_rsp[k].prs2, exp_rsp.prs2, $sformatf("lane %0d prs2", k));
      check_val(ren_rsp[k].old_prd, exp_rsp.old_prd, $sformatf("lane %0d old_prd", k));
    end
  endtask

  task automatic rand_group(input int n);
    rename_pkg::ren_req_t [DW-1:0] rq;
    logic [DW-1:0]                 valid;
    int                            r;
    for (int k = 0; k < DW; k++) begin
      r        = $random(seed);
      rq[k]    = mk_req(r, r >>> 8, r >>> 16);
      valid[k] = k < n;
    end
    rename_cycle(valid, rq);
  endtask

  // Retire the oldest in-flight instructions in order
  task automatic commit_cycle(input int n);
    rename_pkg::commit_t inst;
    @(negedge clk);
    flush     = 1'b0;
    ren_valid = '0;
    cm_valid  = '0;
    cm        = '0;
    for (int k = 0; k < CW; k++) begin
      if (k < n && inflight_q.size() > 0) begin
        inst        = inflight_q.pop_front();
        cm[k]       = inst;
        cm_valid[k] = 1'b1;
        free_q.push_back(inst.old_prd);
        void'(arch_free_q.pop_front());
        arch_free_q.push_back(inst.old_prd);
        arch_map[inst.rd] = inst.prd;
      end
    end
  endtask

  task automatic commit_all();
    while (inflight_q.size() > 0) begin
      commit_cycle(CW);
    end
  endtask

  // Speculative state falls back to the committed copy
  task automatic flush_cycle();
    @(negedge clk);
    flush     = 1'b1;
    ren_valid = '0;
    cm_valid  = '0;
    spec_map  = arch_map;
    free_q    = arch_free_q;
    inflight_q.delete();
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (errors_now() == err_base) begin
      $display("[%0t] %s: clean", $time, name);
    end else begin
      bad_tests++;
      $display("[%0t] %s: %0d errors", $time, name, errors_now() - err_base);
    end
    err_base = errors_now();
  endtask

  // ==============================
  // Test sequence
  // ==============================
  initial begin
    rst_n     = 1'b0;
    flush     = 1'b0;
    ren_valid = '0;
    ren_req   = '0;
    cm_valid  = '0;
    cm        = '0;
    for (int i = 0; i < AN; i++) begin
      spec_map[i] = rename_pkg::preg_t'(i);
      arch_map[i] = rename_pkg::preg_t'(i);
    end
    // Free registers start above the architectural ones
    for (int i = AN; i < PN; i++) begin
      free_q.push_back(rename_pkg::preg_t'(i));
    end
    arch_free_q = free_q;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // Allocation order, identity lookups, then reuse of freed registers
    reqs[0] = mk_req(1, 5, 6);
    reqs[1] = mk_req(2, 7, 8);
    rename_cycle('1, reqs);
    repeat (15) rand_group(DW);
    commit_all();
    repeat (16) rand_group(DW);
    commit_all();
    end_test("alloc_order");

    // Drain to one free entry, stall, then commits reopen the port
    repeat (15) rand_group(DW);
    rand_group(1);
    rand_group(DW);
    rand_group(1);
    commit_cycle(1);
    rand_group(DW);
    rand_group(1);
    commit_all();
    end_test("ready_rule");

    // Reads after writes from earlier cycles
    reqs[0] = mk_req(7, 0, 31);
    reqs[1] = mk_req(9, 3, 4);
    rename_cycle('1, reqs);
    reqs[0] = mk_req(7, 7, 9);
    reqs[1] = mk_req(20, 9, 7);
    rename_cycle('1, reqs);
    reqs[0] = mk_req(21, 7, 20);
    rename_cycle(DW'(1), reqs);
    commit_all();
    end_test("map_lookup");

    // Lane 1 depends on lane 0 inside one group
    reqs[0] = mk_req(10, 1, 2);
    reqs[1] = mk_req(10, 10, 10);
    rename_cycle('1, reqs);
    reqs[0] = mk_req(11, 11, 3);
    reqs[1] = mk_req(12, 4, 11);
    rename_cycle('1, reqs);
    commit_all();
    end_test("bypass");

    // Partial commit, more speculation, flush, then sweep the whole map
    repeat (6) rand_group(DW);
    commit_cycle(2);
    commit_cycle(1);
    repeat (4) rand_group(DW);
    flush_cycle();
    for (int g = 0; g < AN / 4; g++) begin
      reqs[0] = mk_req(4 * g, 4 * g, 4 * g + 1);
      reqs[1] = mk_req(4 * g + 2, 4 * g + 2, 4 * g + 3);
      rename_cycle('1, reqs);
    end
    commit_all();
    end_test("commit_flush");

    @(negedge clk);
    cm_valid  = '0;
    ren_valid = '0;
    repeat (2) @(negedge clk);
    $display("summary: %0d tests, %0d with errors, %0d checks, %0d value errors, %0d assertion fails",
             test_cnt, bad_tests, check_cnt, err_cnt,
             u_rename_unit.u_rename_checker.fail_cnt);
    if (errors_now() == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
hw/rename_pkg.sv
hw/free_list.sv
hw/map_table.sv
hw/commit_tracker.sv
hw/rename_merge.sv
hw/rename_unit.sv
dv/rename_checker.sv
dv/rename_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the rename unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module rename_tb -o rename_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "build failed"
  exit 1
fi

./obj_dir/rename_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  exit 0
fi
exit 1
